// File: fpu_types_pkg.sv
// Binary32 format definitions shared by the compare-and-move datapath.
// Import this package wherever an operand or a class mask is handled.

package fpu_types_pkg;

    // -------------------------------------------------------------------------
    // Operand format
    // -------------------------------------------------------------------------

    // IEEE-754 single precision, sign in the top bit
    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [22:0] significand;
    } float32_t;

    // -------------------------------------------------------------------------
    // Format constants
    // -------------------------------------------------------------------------

    // All-ones exponent marks infinities and NaNs
    localparam logic [7:0] EXP_MAX = 8'hFF;

    // A set top significand bit makes a NaN quiet, a clear one makes it signaling
    localparam int unsigned QUIET_BIT = 22;

    // Positive quiet NaN with only the quiet bit set in the significand
    localparam float32_t CANONICAL_NAN = 32'h7FC0_0000;

    // Ten classes, one bit each, as returned by the classify operation
    localparam int unsigned CLASS_WIDTH = 10;

endpackage : fpu_types_pkg

// File: fpu_ops_pkg.sv
// Opcode and internal select encodings of the compare-and-move unit.
// The control module decodes the opcode into the datapath selects below.

package fpu_ops_pkg;

    // Operations accepted on the opcode input of the unit
    typedef enum logic [3:0] {
        OP_FEQ    = 4'd0,
        OP_FLT    = 4'd1,
        OP_FLE    = 4'd2,
        OP_FMIN   = 4'd3,
        OP_FMAX   = 4'd4,
        OP_FCLASS = 4'd5,
        OP_FSGNJ  = 4'd6,
        OP_FSGNJN = 4'd7,
        OP_FSGNJX = 4'd8
    } fpu_misc_op_t;

    // Comparator relation, "or equal" comes on a separate input
    typedef enum logic [1:0] {
        FP_EQ = 2'd0,
        FP_LT = 2'd1,
        FP_GT = 2'd2
    } fcmp_operation_t;

    // Source of the result sign for sign injection
    typedef enum logic [1:0] {
        SGNJ_COPY = 2'd0,
        SGNJ_NEG  = 2'd1,
        SGNJ_XOR  = 2'd2
    } sgnj_mode_t;

    // Result multiplexer select inside the control module
    typedef enum logic [1:0] {
        SEL_CMP   = 2'd0,
        SEL_CLASS = 2'd1,
        SEL_SGNJ  = 2'd2
    } result_sel_t;

endpackage : fpu_ops_pkg

// File: fp_comparator.sv
// Combinational binary32 comparator with NaN handling.
// Returns either a flag in bit 0 or the operand that satisfies the relation,
// which serves both the compare opcodes and minimum/maximum.

module fp_comparator import fpu_types_pkg::*, fpu_ops_pkg::*; (
    input  float32_t        operand_a_i,
    input  float32_t        operand_b_i,
    input  fcmp_operation_t operation_i,
    input  logic            equals_i,
    input  logic            flag_i,
    output float32_t        result_o,
    output logic            invalid_operation_o
);

    // -------------------------------------------------------------------------
    // Field comparison
    // -------------------------------------------------------------------------

    // Outcome of comparing one field of A against the same field of B
    typedef struct packed {
        logic equals;
        logic less;
    } cmp_outcome_t;

    cmp_outcome_t exponent_cmp;
    cmp_outcome_t significand_cmp;

    always_comb begin
        exponent_cmp.equals = (operand_a_i.exponent == operand_b_i.exponent);
        exponent_cmp.less   = (operand_a_i.exponent < operand_b_i.exponent);
    end

    always_comb begin
        significand_cmp.equals = (operand_a_i.significand == operand_b_i.significand);
        significand_cmp.less   = (operand_a_i.significand < operand_b_i.significand);
    end

    // Magnitude order, the exponent has priority over the significand
    logic magnitude_eq;
    logic magnitude_lt;
    logic magnitude_gt;

    assign magnitude_eq = exponent_cmp.equals & significand_cmp.equals;
    assign magnitude_lt = exponent_cmp.less | (exponent_cmp.equals & significand_cmp.less);
    assign magnitude_gt = !magnitude_eq & !magnitude_lt;

    // Signed order: with different signs the negative operand is less,
    // with equal negative signs the larger magnitude is less
    logic signs_differ;
    logic ordered_lt;
    logic bitwise_eq;

    assign signs_differ = operand_a_i.sign ^ operand_b_i.sign;
    assign ordered_lt   = signs_differ ? operand_a_i.sign
                        : (operand_a_i.sign ? magnitude_gt : magnitude_lt);
    assign bitwise_eq   = !signs_differ & magnitude_eq;

    // Flags treat +0 and -0 as equal, operand selection keeps -0 below +0
    logic both_zero;
    logic rel_eq;
    logic rel_lt;
    logic rel_gt;

    assign both_zero = (operand_a_i.exponent == '0) && (operand_a_i.significand == '0)
                    && (operand_b_i.exponent == '0) && (operand_b_i.significand == '0);
    assign rel_eq    = flag_i ? (bitwise_eq | both_zero) : bitwise_eq;
    assign rel_lt    = flag_i ? (ordered_lt & !both_zero) : ordered_lt;
    assign rel_gt    = !rel_eq & !rel_lt;

    // -------------------------------------------------------------------------
    // NaN detection
    // -------------------------------------------------------------------------

    logic a_is_nan, b_is_nan;
    logic a_is_snan, b_is_snan;
    logic any_nan, any_snan;

    assign a_is_nan  = (operand_a_i.exponent == EXP_MAX) && (operand_a_i.significand != '0);
    assign b_is_nan  = (operand_b_i.exponent == EXP_MAX) && (operand_b_i.significand != '0);
    assign a_is_snan = a_is_nan & !operand_a_i.significand[QUIET_BIT];
    assign b_is_snan = b_is_nan & !operand_b_i.significand[QUIET_BIT];
    assign any_nan   = a_is_nan | b_is_nan;
    assign any_snan  = a_is_snan | b_is_snan;

    // -------------------------------------------------------------------------
    // Outcome
    // -------------------------------------------------------------------------

    // True when A satisfies the requested relation against B
    logic hit;

    always_comb begin
        case (operation_i)
            FP_EQ:   hit = rel_eq;
            FP_LT:   hit = rel_lt | (equals_i & rel_eq);
            FP_GT:   hit = rel_gt | (equals_i & rel_eq);
            default: hit = 1'b0;
        endcase
    end

    always_comb begin
        if (flag_i) begin
            // A NaN is unordered, so every relation is false
            result_o = float32_t'({31'b0, hit & !any_nan});

            // Quiet NaNs only trip the ordered relations
            invalid_operation_o = (operation_i == FP_EQ) ? any_snan : any_nan;
        end else begin
            // A single NaN loses to the number, two NaNs give the canonical one
            case ({a_is_nan, b_is_nan})
                2'b00:   result_o = hit ? operand_a_i : operand_b_i;
                2'b01:   result_o = operand_a_i;
                2'b10:   result_o = operand_b_i;
                default: result_o = CANONICAL_NAN;
            endcase
            invalid_operation_o = any_snan;
        end
    end

    // The flag may only come from a NaN on one of the two operands
    always_comb begin
        assert (!invalid_operation_o || a_is_nan || b_is_nan)
            else $error("comparator raised invalid without a NaN operand");
    end

endmodule : fp_comparator

// File: fp_classifier.sv
// Class mask of one binary32 operand, as used by the classify opcode.
// Exactly one of the ten bits is set for any input pattern.

module fp_classifier import fpu_types_pkg::*; (
    input  float32_t               operand_i,
    output logic [CLASS_WIDTH-1:0] class_mask_o
);

    // Field tests on the operand
    logic exp_zero;
    logic exp_max;
    logic sig_zero;
    logic is_quiet;

    assign exp_zero = (operand_i.exponent == '0);
    assign exp_max  = (operand_i.exponent == EXP_MAX);
    assign sig_zero = (operand_i.significand == '0);
    assign is_quiet = operand_i.significand[QUIET_BIT];

    // Category independent of the sign
    logic is_zero, is_subnormal, is_normal, is_inf, is_nan;

    assign is_zero      = exp_zero & sig_zero;
    assign is_subnormal = exp_zero & !sig_zero;
    assign is_inf       = exp_max & sig_zero;
    assign is_nan       = exp_max & !sig_zero;
    assign is_normal    = !exp_zero & !exp_max;

    logic neg;

    assign neg = operand_i.sign;

    // Bit order runs from negative infinity up to positive infinity,
    // then the two NaN kinds, whose sign is ignored
    always_comb begin
        class_mask_o    = '0;
        class_mask_o[0] = neg & is_inf;
        class_mask_o[1] = neg & is_normal;
        class_mask_o[2] = neg & is_subnormal;
        class_mask_o[3] = neg & is_zero;
        class_mask_o[4] = !neg & is_zero;
        class_mask_o[5] = !neg & is_subnormal;
        class_mask_o[6] = !neg & is_normal;
        class_mask_o[7] = !neg & is_inf;
        class_mask_o[8] = is_nan & !is_quiet;
        class_mask_o[9] = is_nan & is_quiet;
    end

    always_comb begin
        assert ($onehot(class_mask_o))
            else $error("class mask %h is not one-hot", class_mask_o);
    end

endmodule : fp_classifier

// File: fp_sign_injector.sv
// Sign injection on binary32 operands.
// The magnitude always comes from A; the mode picks where the sign comes from.

module fp_sign_injector import fpu_types_pkg::*, fpu_ops_pkg::*; (
    input  float32_t   operand_a_i,
    input  float32_t   operand_b_i,
    input  sgnj_mode_t mode_i,
    output float32_t   result_o
);

    logic new_sign;

    // NaNs pass through untouched apart from the sign bit
    always_comb begin
        case (mode_i)
            SGNJ_COPY: new_sign = operand_b_i.sign;
            SGNJ_NEG:  new_sign = !operand_b_i.sign;
            SGNJ_XOR:  new_sign = operand_a_i.sign ^ operand_b_i.sign;
            default:   new_sign = operand_a_i.sign;
        endcase
    end

    always_comb begin
        result_o.sign        = new_sign;
        result_o.exponent    = operand_a_i.exponent;
        result_o.significand = operand_a_i.significand;
    end

    // Only the sign may differ from A, whatever the mode
    always_comb begin
        assert (result_o[30:0] == operand_a_i[30:0])
            else $error("sign injection changed the magnitude of A");
    end

endmodule : fp_sign_injector

// File: fpu_misc_ctrl.sv
// Opcode decoder, result multiplexer and output register of the unit.
// Steers the combinational datapath and holds the only pipeline stage.

module fpu_misc_ctrl import fpu_types_pkg::*, fpu_ops_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   valid_i,
    input  fpu_misc_op_t           opcode_i,
    input  float32_t               cmp_result_i,
    input  logic                   cmp_invalid_i,
    input  logic [CLASS_WIDTH-1:0] class_mask_i,
    input  float32_t               sgnj_result_i,
    output fcmp_operation_t        cmp_op_o,
    output logic                   cmp_equals_o,
    output logic                   cmp_flag_o,
    output sgnj_mode_t             sgnj_mode_o,
    output float32_t               result_o,
    output logic                   invalid_o,
    output logic                   valid_o
);

    // -------------------------------------------------------------------------
    // Opcode decode
    // -------------------------------------------------------------------------

    result_sel_t result_sel;
    logic        keep_invalid;

    always_comb begin
        // Undefined opcodes fall back to an equality flag with no exception
        cmp_op_o     = FP_EQ;
        cmp_equals_o = 1'b0;
        cmp_flag_o   = 1'b1;
        sgnj_mode_o  = SGNJ_COPY;
        result_sel   = SEL_CMP;
        keep_invalid = 1'b0;

        case (opcode_i)
            OP_FEQ: begin
                keep_invalid = 1'b1;
            end
            OP_FLT: begin
                cmp_op_o     = FP_LT;
                keep_invalid = 1'b1;
            end
            OP_FLE: begin
                cmp_op_o     = FP_LT;
                cmp_equals_o = 1'b1;
                keep_invalid = 1'b1;
            end
            // Min and max reuse the ordered compare in operand-select mode
            OP_FMIN: begin
                cmp_op_o     = FP_LT;
                cmp_flag_o   = 1'b0;
                keep_invalid = 1'b1;
            end
            OP_FMAX: begin
                cmp_op_o     = FP_GT;
                cmp_flag_o   = 1'b0;
                keep_invalid = 1'b1;
            end
            OP_FCLASS: result_sel = SEL_CLASS;
            OP_FSGNJ:  result_sel = SEL_SGNJ;
            OP_FSGNJN: begin
                result_sel  = SEL_SGNJ;
                sgnj_mode_o = SGNJ_NEG;
            end
            OP_FSGNJX: begin
                result_sel  = SEL_SGNJ;
                sgnj_mode_o = SGNJ_XOR;
            end
            default: ;
        endcase
    end

    // -------------------------------------------------------------------------
    // Result selection and output stage
    // -------------------------------------------------------------------------

    float32_t next_result;
    logic     next_invalid;

    always_comb begin
        case (result_sel)
            SEL_CLASS: next_result = float32_t'({{(32-CLASS_WIDTH){1'b0}}, class_mask_i});
            SEL_SGNJ:  next_result = sgnj_result_i;
            default:   next_result = cmp_result_i;
        endcase
    end

    // The comparator's flag is meaningless for classify and sign injection
    assign next_invalid = keep_invalid & cmp_invalid_i;

    // Result and flag update only with a new item, valid follows the strobe
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_o  <= '0;
            invalid_o <= 1'b0;
            valid_o   <= 1'b0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                result_o  <= next_result;
                invalid_o <= next_invalid;
            end
        end
    end

    a_valid_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(valid_o));

    // An item that cannot raise invalid must leave the flag clear a cycle later
    a_no_invalid_moves: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i && (opcode_i inside {OP_FCLASS, OP_FSGNJ, OP_FSGNJN, OP_FSGNJX})
        |=> !invalid_o);

endmodule : fpu_misc_ctrl

// File: fpu_misc_unit.sv
// Top level of the compare-and-move unit, one registered stage.
// Connects the control module to the comparator, classifier and sign injector.

module fpu_misc_unit import fpu_types_pkg::*, fpu_ops_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         valid_i,
    input  fpu_misc_op_t opcode_i,
    input  float32_t     operand_a_i,
    input  float32_t     operand_b_i,
    output float32_t     result_o,
    output logic         valid_o,
    output logic         invalid_o
);

    // Datapath selects from the decoder
    fcmp_operation_t cmp_op;
    logic            cmp_equals;
    logic            cmp_flag;
    sgnj_mode_t      sgnj_mode;

    // Candidate results back to the output multiplexer
    float32_t               cmp_result;
    logic                   cmp_invalid;
    logic [CLASS_WIDTH-1:0] class_mask;
    float32_t               sgnj_result;

    fpu_misc_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .valid_i       (valid_i),
        .opcode_i      (opcode_i),
        .cmp_result_i  (cmp_result),
        .cmp_invalid_i (cmp_invalid),
        .class_mask_i  (class_mask),
        .sgnj_result_i (sgnj_result),
        .cmp_op_o      (cmp_op),
        .cmp_equals_o  (cmp_equals),
        .cmp_flag_o    (cmp_flag),
        .sgnj_mode_o   (sgnj_mode),
        .result_o      (result_o),
        .invalid_o     (invalid_o),
        .valid_o       (valid_o)
    );

    fp_comparator u_comparator (
        .operand_a_i         (operand_a_i),
        .operand_b_i         (operand_b_i),
        .operation_i         (cmp_op),
        .equals_i            (cmp_equals),
        .flag_i              (cmp_flag),
        .result_o            (cmp_result),
        .invalid_operation_o (cmp_invalid)
    );

    // Classify looks at operand A only
    fp_classifier u_classifier (
        .operand_i    (operand_a_i),
        .class_mask_o (class_mask)
    );

    fp_sign_injector u_sign_injector (
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .mode_i      (sgnj_mode),
        .result_o    (sgnj_result)
    );

endmodule : fpu_misc_unit

// File: tb_fpu_misc.sv
// Self-checking testbench for the compare-and-move unit.
// Drives directed special-value pairs and random items, predicts each result
// with a reference model and compares it when valid_o comes back.

module tb_fpu_misc import fpu_types_pkg::*, fpu_ops_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 4;
    localparam int NUM_OPS      = 9;
    localparam int NUM_SPECIALS = 14;
    localparam int N_RANDOM     = 600;
    localparam int NUM_VECTORS  = 1 + NUM_OPS * NUM_SPECIALS * NUM_SPECIALS + N_RANDOM;

    // Zeros, ones, infinities, both NaN kinds, subnormals and the largest normal
    localparam logic [31:0] SPECIAL_VALUES [NUM_SPECIALS] = '{
        32'h0000_0000, 32'h8000_0000, 32'h3F80_0000, 32'hBF80_0000,
        32'h7F80_0000, 32'hFF80_0000, 32'h7FC0_0000, 32'hFFC0_0000,
        32'h7F80_0001, 32'hFFA0_0000, 32'h0000_0001, 32'h807F_FFFF,
        32'h7F7F_FFFF, 32'hFF7F_FFFF
    };

    typedef struct packed {
        logic [31:0] due_cycle;
        logic        invalid;
        logic [31:0] result;
    } expect_t;

    logic         clk_i = 1'b0;
    logic         rst_n_i;
    logic         valid_i;
    fpu_misc_op_t opcode_i;
    float32_t     operand_a_i;
    float32_t     operand_b_i;
    float32_t     result_o;
    logic         valid_o;
    logic         invalid_o;

    integer      seed = 37006;
    logic [31:0] cycle = '0;
    expect_t     expected_q[$];
    expect_t     head;
    logic [31:0] last_result = '0;
    logic        last_invalid = 1'b0;

    fpu_misc_unit UUT (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    always @(posedge clk_i) cycle <= cycle + 32'd1;

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    function automatic logic is_nan(logic [31:0] x);
        return (x[30:23] == 8'hFF) && (x[22:0] != '0);
    endfunction

    function automatic logic is_snan(logic [31:0] x);
        return is_nan(x) && !x[22];
    endfunction

    // Signed integer whose order follows the numeric order, both zeros map to 0
    function automatic logic signed [32:0] order_key(logic [31:0] x);
        logic signed [32:0] mag;
        mag = {2'b00, x[30:0]};
        return x[31] ? -mag : mag;
    endfunction

    function automatic logic [CLASS_WIDTH-1:0] class_of(logic [31:0] x);
        int idx;
        if (is_nan(x))                 idx = x[22] ? 9 : 8;
        else if (x[30:23] == 8'hFF)    idx = x[31] ? 0 : 7;
        else if (x[30:23] != 8'h00)    idx = x[31] ? 1 : 6;
        else if (x[22:0] != '0)        idx = x[31] ? 2 : 5;
        else                           idx = x[31] ? 3 : 4;
        return 10'b1 << idx;
    endfunction

    // Returns the invalid flag above the 32-bit result
    function automatic logic [32:0] fpu_ref_model(fpu_misc_op_t op, logic [31:0] a,
                                                  logic [31:0] b);
        logic        any_nan;
        logic        any_snan;
        logic        both_zero;
        logic        a_below;
        logic        inv;
        logic [31:0] res;
        any_nan   = is_nan(a) || is_nan(b);
        any_snan  = is_snan(a) || is_snan(b);
        both_zero = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);
        // Total order for min and max puts -0 below +0
        a_below   = (order_key(a) < order_key(b)) || (both_zero && a[31] && !b[31]);
        inv       = 1'b0;
        res       = '0;
        case (op)
            OP_FEQ: begin
                inv    = any_snan;
                res[0] = !any_nan && ((a == b) || both_zero);
            end
            OP_FLT: begin
                inv    = any_nan;
                res[0] = !any_nan && (order_key(a) < order_key(b));
            end
            OP_FLE: begin
                inv    = any_nan;
                res[0] = !any_nan && (order_key(a) <= order_key(b));
            end
            OP_FMIN, OP_FMAX: begin
                inv = any_snan;
                if (is_nan(a) && is_nan(b)) res = CANONICAL_NAN;
                else if (is_nan(a))         res = b;
                else if (is_nan(b))         res = a;
                else                        res = ((op == OP_FMIN) == a_below) ? a : b;
            end
            OP_FCLASS: res = {{(32-CLASS_WIDTH){1'b0}}, class_of(a)};
            OP_FSGNJ:  res = {b[31], a[30:0]};
            OP_FSGNJN: res = {~b[31], a[30:0]};
            OP_FSGNJX: res = {a[31] ^ b[31], a[30:0]};
            default:   res = '0;
        endcase
        return {inv, res};
    endfunction

    // ------------------------------------------------------------------------
    // Error reporting
    // ------------------------------------------------------------------------

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("CHECK FAILED: %s = %h, expected %h at cycle %0d", name, got, exp, cycle);
        $display("Simulation failed");
        $fatal(1, "output mismatch");
    endtask

    task automatic stop_on_error(string msg);
        $display("ERROR: %s at cycle %0d", msg, cycle);
        $display("Simulation failed");
        $fatal(1, "protocol error");
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    // The DUT samples on the next edge, so the result is seen two edges on
    task automatic drive_item(fpu_misc_op_t op, logic [31:0] a, logic [31:0] b);
        expect_t     exp;
        logic [32:0] ref_out;
        @(posedge clk_i);
        valid_i     <= 1'b1;
        opcode_i    <= op;
        operand_a_i <= a;
        operand_b_i <= b;
        ref_out       = fpu_ref_model(op, a, b);
        exp.due_cycle = cycle + 32'd2;
        exp.invalid   = ref_out[32];
        exp.result    = ref_out[31:0];
        expected_q.push_back(exp);
    endtask

    // Idle cycles carry junk operands that the output stage must ignore
    task automatic idle_cycle();
        @(posedge clk_i);
        valid_i     <= 1'b0;
        operand_a_i <= $random(seed);
        operand_b_i <= $random(seed);
    endtask

    // One in four operands comes from the special-value table
    task automatic pick_operand(output logic [31:0] value);
        logic [31:0] r;
        r = $random(seed);
        if (r[1:0] == 2'b00) value = SPECIAL_VALUES[r[7:4] % NUM_SPECIALS];
        else                 value = $random(seed);
    endtask

    task automatic random_item();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        r = $random(seed);
        r = r % NUM_OPS;
        pick_operand(a);
        pick_operand(b);
        // Equal operands now and then so that the equal cases come up
        if (($random(seed) & 7) == 0) b = a;
        drive_item(fpu_misc_op_t'(r[3:0]), a, b);
    endtask

    initial begin
        rst_n_i     = 1'b0;
        valid_i     = 1'b0;
        opcode_i    = OP_FEQ;
        operand_a_i = '0;
        operand_b_i = '0;
        repeat (4) @(posedge clk_i);
        rst_n_i <= 1'b1;
        repeat (2) idle_cycle();

        // A lone item first, then every special pair for every opcode back to back
        drive_item(OP_FLT, 32'hBF80_0000, 32'h3F80_0000);
        repeat (3) idle_cycle();
        for (int op = 0; op < NUM_OPS; op++) begin
            for (int i = 0; i < NUM_SPECIALS; i++) begin
                for (int j = 0; j < NUM_SPECIALS; j++) begin
                    drive_item(fpu_misc_op_t'(op[3:0]), SPECIAL_VALUES[i], SPECIAL_VALUES[j]);
                end
            end
        end
        idle_cycle();

        for (int n = 0; n < N_RANDOM; n++) begin
            random_item();
            if (($random(seed) & 3) == 0) idle_cycle();
        end
        repeat (4) idle_cycle();

        if (expected_q.size() != 0) begin
            $display("ERROR: %0d items never came back", expected_q.size());
            $display("Simulation failed");
            $fatal(1, "items lost");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Comparer and watchdog
    // ------------------------------------------------------------------------

    // Outputs are read at the edge before the DUT updates them
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            assert (!$isunknown(valid_o)) else stop_on_error("valid_o is unknown");
            if (valid_o) begin
                if (expected_q.size() == 0) begin
                    stop_on_error("valid_o is high with no item outstanding");
                end else begin
                    head = expected_q.pop_front();
                    if (head.due_cycle != cycle) stop_on_error("result came at the wrong cycle");
                    assert (result_o === head.result)
                        else report_mismatch("result_o", result_o, head.result);
                    assert (invalid_o === head.invalid)
                        else report_mismatch("invalid_o", {31'b0, invalid_o}, {31'b0, head.invalid});
                    last_result  = head.result;
                    last_invalid = head.invalid;
                end
            end else begin
                if (expected_q.size() != 0 && expected_q[0].due_cycle <= cycle)
                    stop_on_error("an item did not raise valid_o");
                // Outputs hold their last value, or zero right after reset
                assert (result_o === last_result)
                    else report_mismatch("result_o", result_o, last_result);
                assert (invalid_o === last_invalid)
                    else report_mismatch("invalid_o", {31'b0, invalid_o}, {31'b0, last_invalid});
            end
        end
    end

    initial begin
        #(NUM_VECTORS * CLK_PERIOD * 4);
        $display("ERROR: watchdog expired before the tests finished");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

endmodule : tb_fpu_misc

// File: tb.f
fpu_types_pkg.sv
fpu_ops_pkg.sv
fp_comparator.sv
fp_classifier.sv
fp_sign_injector.sv
fpu_misc_ctrl.sv
fpu_misc_unit.sv
tb_fpu_misc.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_fpu_misc \
    -Mdir obj_dir \
    -f tb.f

./obj_dir/Vtb_fpu_misc
